//--- design/accel_consts.svh
//////////////////////////////////////////////////////////////////////
// accelerator control constants
// widths, depths, burst length and bank count
//////////////////////////////////////////////////////////////////////
`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

// instruction memory
`define ACC_IM_DEPTH 64
`define ACC_IM_AW 6
`define ACC_INSTR_W 64

// instructions per start
`define ACC_BURST 16

// feature banks
`define ACC_NBANKS 4
`define ACC_BANK_DEPTH 16
`define ACC_BANK_AW 4

// feature word
`define ACC_DATA_W 16

`endif

//--- design/accel_pkg.sv
//////////////////////////////////////////////////////////////////////
// accelerator control types
// opcodes, fetch states, instruction and bank command layouts
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "accel_consts.svh"

package accel_pkg;

  // supported opcodes, anything else decodes to nop
  typedef enum logic [7:0] {
    OP_NOP  = 8'h00,
    OP_LOAD = 8'h04,
    OP_ACC  = 8'h81
  } op_e;

  // burst fetch sequencer
  typedef enum logic [1:0] {
    FS_IDLE  = 2'd0,
    FS_READ  = 2'd1,
    FS_DRAIN = 2'd2
  } fetch_state_e;

  // 64-bit instruction, msb first
  typedef struct packed {
    logic [7:0]             opcode;
    logic [7:0]             f_type;
    logic [`ACC_DATA_W-1:0] src;
    logic [`ACC_DATA_W-1:0] dst;
    logic [7:0]             memsel;
    logic [7:0]             pad;
  } instr_t;

  // command broadcast to all banks
  typedef struct packed {
    op_e                     op;
    logic [`ACC_BANK_AW-1:0] addr;
    logic [`ACC_DATA_W-1:0]  data;
  } bank_cmd_t;

endpackage

`default_nettype wire

//--- design/instr_mem.sv
//////////////////////////////////////////////////////////////////////
// instruction memory, 64 x 64 bit
// host write port, registered read port for the fetch unit
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module instr_mem (
  input  wire                    clk,
  input  wire                    rst,
  // host write port
  input  wire                    i_we,
  input  wire [`ACC_IM_AW-1:0]   i_waddr,
  input  wire [`ACC_INSTR_W-1:0] i_wdata,
  // fetch read port
  input  wire                    i_rd_en,
  input  wire [`ACC_IM_AW-1:0]   i_raddr,
  output logic [`ACC_INSTR_W-1:0] o_rdata
);

  // program storage, contents survive reset
  logic [`ACC_INSTR_W-1:0] mem [`ACC_IM_DEPTH];

  // host writes land in one cycle
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // read data one cycle after the enable
  // holds last word when not reading
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rdata <= '0;
    end else if (i_rd_en) begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule

`default_nettype wire

//--- design/instr_fetch.sv
//////////////////////////////////////////////////////////////////////
// burst instruction fetch
// reads 16 words from a base address and strobes them to decode
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module instr_fetch (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      i_start,
  input  wire [`ACC_IM_AW-1:0]     i_base_addr,
  input  wire [`ACC_INSTR_W-1:0]   i_mem_rdata,
  output logic                     o_mem_rd_en,
  output logic [`ACC_IM_AW-1:0]    o_mem_addr,
  output accel_pkg::instr_t        o_instr,
  output logic                     o_instr_en,
  output logic                     o_busy,
  output logic                     o_done
);

  import accel_pkg::*;

  localparam int AW = `ACC_IM_AW;
  // last read of the burst
  localparam logic [4:0] READ_LAST = 5'(`ACC_BURST - 1);
  // two cycles for decode and bank stages
  localparam logic [4:0] DRAIN_LAST = 5'd1;

  fetch_state_e state;
  logic [4:0] burst_cnt;
  logic [AW-1:0] base_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FS_IDLE;
      burst_cnt <= '0;
      base_q <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        FS_IDLE: begin
          // start only accepted when idle
          if (i_start) begin
            state <= FS_READ;
            burst_cnt <= '0;
            base_q <= i_base_addr;
          end
        end
        FS_READ: begin
          if (burst_cnt == READ_LAST) begin
            state <= FS_DRAIN;
            burst_cnt <= '0;
          end else begin
            burst_cnt <= burst_cnt + 5'd1;
          end
        end
        FS_DRAIN: begin
          // last bank command issued, report done
          if (burst_cnt == DRAIN_LAST) begin
            state <= FS_IDLE;
            burst_cnt <= '0;
            o_done <= 1'b1;
          end else begin
            burst_cnt <= burst_cnt + 5'd1;
          end
        end
        default: state <= FS_IDLE;
      endcase
    end
  end

  // read port, address wraps modulo memory depth
  assign o_mem_rd_en = (state == FS_READ);
  assign o_mem_addr  = base_q + AW'(burst_cnt);
  assign o_busy      = (state != FS_IDLE);

  // strobe lines up with registered read data
  always_ff @(posedge clk) begin
    if (rst) begin
      o_instr_en <= 1'b0;
    end else begin
      o_instr_en <= o_mem_rd_en;
    end
  end

  assign o_instr = instr_t'(i_mem_rdata);

endmodule

`default_nettype wire

//--- design/instr_decode.sv
//////////////////////////////////////////////////////////////////////
// instruction decoder
// splits fields and issues one bank command with one-hot enables
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module instr_decode (
  input  wire                       clk,
  input  wire                       rst,
  input  wire accel_pkg::instr_t    i_instr,
  input  wire                       i_instr_en,
  output accel_pkg::bank_cmd_t      o_cmd,
  output logic [`ACC_NBANKS-1:0]    o_bank_en
);

  import accel_pkg::*;

  op_e op_dec;
  logic [`ACC_NBANKS-1:0] bank_en_d;
  bank_cmd_t cmd_d;

  // unknown opcodes fall back to nop
  always_comb begin
    case (i_instr.opcode)
      OP_LOAD: op_dec = OP_LOAD;
      OP_ACC:  op_dec = OP_ACC;
      default: op_dec = OP_NOP;
    endcase
  end

  // f_type and pad are carried but not used here
  always_comb begin
    cmd_d.op   = op_dec;
    // bank word address from low bits of dst
    cmd_d.addr = i_instr.dst[`ACC_BANK_AW-1:0];
    // operand value
    cmd_d.data = i_instr.src;
  end

  // memsel low bits pick the bank
  // nop and idle cycles enable nothing
  always_comb begin
    bank_en_d = '0;
    if (i_instr_en && (op_dec != OP_NOP)) begin
      bank_en_d[i_instr.memsel[1:0]] = 1'b1;
    end
  end

  // registered bank enables
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bank_en <= '0;
    end else begin
      o_bank_en <= bank_en_d;
    end
  end

  // command payload broadcast to every bank
  always_ff @(posedge clk) begin
    o_cmd <= cmd_d;
  end

endmodule

`default_nettype wire

//--- design/feature_bank.sv
//////////////////////////////////////////////////////////////////////
// feature bank, 16 words of 16 bits
// executes load and acc, registered host read port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module feature_bank (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        i_en,
  input  wire accel_pkg::bank_cmd_t  i_cmd,
  input  wire [`ACC_BANK_AW-1:0]     i_rd_addr,
  output logic [`ACC_DATA_W-1:0]     o_rd_data
);

  import accel_pkg::*;

  logic [`ACC_DATA_W-1:0] mem [`ACC_BANK_DEPTH];

  // word update at end of the command cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      // bank contents start at zero
      for (int i = 0; i < `ACC_BANK_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (i_en) begin
      case (i_cmd.op)
        OP_LOAD: mem[i_cmd.addr] <= i_cmd.data;
        // wraps modulo 2^16
        OP_ACC:  mem[i_cmd.addr] <= mem[i_cmd.addr] + i_cmd.data;
        default: ;
      endcase
    end
  end

  // read every cycle, old value on same-cycle update
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rd_data <= '0;
    end else begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- design/bank_readout.sv
//////////////////////////////////////////////////////////////////////
// bank readout
// picks the addressed bank word for the host and registers it
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module bank_readout (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire                                    i_rd_en,
  input  wire [1:0]                              i_rd_bank,
  input  wire [`ACC_NBANKS-1:0][`ACC_DATA_W-1:0] i_bank_data,
  output logic                                   o_rd_valid,
  output logic [`ACC_DATA_W-1:0]                 o_rd_data
);

  // request delayed to match bank read register
  logic rd_en_q;
  logic [1:0] rd_bank_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q <= 1'b0;
      o_rd_valid <= 1'b0;
    end else begin
      rd_en_q <= i_rd_en;
      o_rd_valid <= rd_en_q;
    end
  end

  // bank index lines up with the bank read register
  always_ff @(posedge clk) begin
    rd_bank_q <= i_rd_bank;
    o_rd_data <= i_bank_data[rd_bank_q];
  end

endmodule

`default_nettype wire

//--- design/accel_ctrl_top.sv
//////////////////////////////////////////////////////////////////////
// accelerator control top
// instruction memory, fetch, decode, feature banks and readout
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module accel_ctrl_top (
  input  wire                      clk,
  input  wire                      rst,
  // program load
  input  wire                      i_im_we,
  input  wire [`ACC_IM_AW-1:0]     i_im_addr,
  input  wire [`ACC_INSTR_W-1:0]   i_im_wdata,
  // burst control
  input  wire                      i_start,
  input  wire [`ACC_IM_AW-1:0]     i_base_addr,
  output logic                     o_busy,
  output logic                     o_done,
  // bank readback
  input  wire                      i_rd_en,
  input  wire [1:0]                i_rd_bank,
  input  wire [`ACC_BANK_AW-1:0]   i_rd_addr,
  output logic                     o_rd_valid,
  output logic [`ACC_DATA_W-1:0]   o_rd_data
);

  import accel_pkg::*;

  // memory read side
  logic im_rd_en;
  logic [`ACC_IM_AW-1:0] im_raddr;
  logic [`ACC_INSTR_W-1:0] im_rdata;

  // fetch to decode
  instr_t instr;
  logic instr_en;

  // decode to banks
  bank_cmd_t cmd;
  logic [`ACC_NBANKS-1:0] bank_en;

  // banks to readout
  logic [`ACC_NBANKS-1:0][`ACC_DATA_W-1:0] bank_rd_data;

  instr_mem u_mem (
    .clk     (clk),
    .rst     (rst),
    .i_we    (i_im_we),
    .i_waddr (i_im_addr),
    .i_wdata (i_im_wdata),
    .i_rd_en (im_rd_en),
    .i_raddr (im_raddr),
    .o_rdata (im_rdata)
  );

  instr_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .i_base_addr (i_base_addr),
    .i_mem_rdata (im_rdata),
    .o_mem_rd_en (im_rd_en),
    .o_mem_addr  (im_raddr),
    .o_instr     (instr),
    .o_instr_en  (instr_en),
    .o_busy      (o_busy),
    .o_done      (o_done)
  );

  instr_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .i_instr    (instr),
    .i_instr_en (instr_en),
    .o_cmd      (cmd),
    .o_bank_en  (bank_en)
  );

  // one bank per enable bit, shared command and read address
  for (genvar b = 0; b < `ACC_NBANKS; b++) begin : g_bank
    feature_bank u_bank (
      .clk       (clk),
      .rst       (rst),
      .i_en      (bank_en[b]),
      .i_cmd     (cmd),
      .i_rd_addr (i_rd_addr),
      .o_rd_data (bank_rd_data[b])
    );
  end

  bank_readout u_readout (
    .clk         (clk),
    .rst         (rst),
    .i_rd_en     (i_rd_en),
    .i_rd_bank   (i_rd_bank),
    .i_bank_data (bank_rd_data),
    .o_rd_valid  (o_rd_valid),
    .o_rd_data   (o_rd_data)
  );

endmodule

`default_nettype wire

//--- verification/accel_checker.sv
//////////////////////////////////////////////////////////////////////
// fetch and decode assertions, bound into the control top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module accel_checker (
  input wire                     clk,
  input wire                     rst,
  input wire                     i_start,
  input wire                     i_busy,
  input wire                     i_done,
  input wire                     i_mem_rd_en,
  input wire [`ACC_NBANKS-1:0]   i_bank_en
);

  // length of the current read run
  logic [4:0] run_len;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_len <= '0;
    end else if (i_mem_rd_en) begin
      run_len <= run_len + 5'd1;
    end else begin
      run_len <= '0;
    end
  end

  // at most one bank acts per command
  a_bank_en_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(i_bank_en)) else $error("bank enable has more than one bit set");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    i_done |=> !i_done) else $error("done held for more than one cycle");

  // accepted start opens a read run
  a_start_reads: assert property (@(posedge clk) disable iff (rst)
    (i_start && !i_busy) |=> i_mem_rd_en) else $error("no read after accepted start");

  // run never longer than a burst
  a_read_max: assert property (@(posedge clk) disable iff (rst)
    i_mem_rd_en |-> (run_len < 5'd16)) else $error("read run longer than a burst");

  // and never shorter
  a_read_len: assert property (@(posedge clk) disable iff (rst)
    (!i_mem_rd_en && run_len != 5'd0) |-> (run_len == 5'd16))
    else $error("read run shorter than a burst");

  a_busy_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(i_busy) |-> i_done) else $error("busy dropped without done");

endmodule

// watches the fetch and decode outputs inside the top
bind accel_ctrl_top accel_checker u_checker (
  .clk         (clk),
  .rst         (rst),
  .i_start     (i_start),
  .i_busy      (o_busy),
  .i_done      (o_done),
  .i_mem_rd_en (im_rd_en),
  .i_bank_en   (bank_en)
);

`default_nettype wire

//--- verification/accel_tb.sv
//////////////////////////////////////////////////////////////////////
// accelerator control testbench
// loads programs, runs bursts, checks banks against a reference model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_consts.svh"

module accel_tb;

  import accel_pkg::*;

  // one expected readback, tagged with the cycle it was requested
  typedef struct packed {
    logic [31:0]             cyc;
    logic [1:0]              bank;
    logic [`ACC_BANK_AW-1:0] addr;
    logic [`ACC_DATA_W-1:0]  data;
  } rd_exp_t;

  logic                    clk;
  logic                    rst;
  logic                    i_im_we;
  logic [`ACC_IM_AW-1:0]   i_im_addr;
  logic [`ACC_INSTR_W-1:0] i_im_wdata;
  logic                    i_start;
  logic [`ACC_IM_AW-1:0]   i_base_addr;
  logic                    o_busy;
  logic                    o_done;
  logic                    i_rd_en;
  logic [1:0]              i_rd_bank;
  logic [`ACC_BANK_AW-1:0] i_rd_addr;
  logic                    o_rd_valid;
  logic [`ACC_DATA_W-1:0]  o_rd_data;

  // reference bank contents
  logic [`ACC_DATA_W-1:0] ref_mem [`ACC_NBANKS][`ACC_BANK_DEPTH];
  // program for the next burst
  instr_t prog [`ACC_BURST];
  // readbacks still in flight
  rd_exp_t exp_q [$];
  rd_exp_t exp_head;
  logic [31:0] cycle_cnt = '0;

  accel_ctrl_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .i_im_we     (i_im_we),
    .i_im_addr   (i_im_addr),
    .i_im_wdata  (i_im_wdata),
    .i_start     (i_start),
    .i_base_addr (i_base_addr),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .i_rd_en     (i_rd_en),
    .i_rd_bank   (i_rd_bank),
    .i_rd_addr   (i_rd_addr),
    .o_rd_valid  (o_rd_valid),
    .o_rd_data   (o_rd_data)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 32'd1;
  end

  task automatic stop_with_error(input string msg);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_with_error($sformatf("%s has a wrong value", name));
    end
  endtask

  // opcode rules: 04 loads src, 81 adds src mod 2^16, rest do nothing
  function automatic void apply_ref(input instr_t ins);
    logic [1:0] b;
    logic [3:0] a;
    b = ins.memsel[1:0];
    a = ins.dst[3:0];
    case (ins.opcode)
      8'h04: ref_mem[b][a] = ins.src;
      8'h81: ref_mem[b][a] = ref_mem[b][a] + ins.src;
      default: ;
    endcase
  endfunction

  // unused fields and upper dst / memsel bits carry junk on purpose
  function automatic instr_t make_instr(input logic [7:0] op, input logic [15:0] src,
                                        input logic [3:0] addr, input logic [1:0] bank);
    instr_t ins;
    ins.opcode = op;
    ins.f_type = 8'h5a;
    ins.src    = src;
    ins.dst    = {12'ha5c, addr};
    ins.memsel = {6'h2b, bank};
    ins.pad    = 8'hc3;
    return ins;
  endfunction

  // program goes to base .. base+15, wrapping at 64
  task automatic load_program(input logic [`ACC_IM_AW-1:0] base);
    for (int i = 0; i < `ACC_BURST; i++) begin
      @(posedge clk);
      #2;
      i_im_we    = 1'b1;
      i_im_addr  = base + 6'(i);
      i_im_wdata = prog[i];
    end
    @(posedge clk);
    #2;
    i_im_we = 1'b0;
  endtask

  // start, optional second start while busy, wait for done
  task automatic run_burst(input logic [`ACC_IM_AW-1:0] base, input bit restart);
    int cyc;
    bit done_seen;
    cyc = 0;
    done_seen = 1'b0;
    @(posedge clk);
    #2;
    i_start     = 1'b1;
    i_base_addr = base;
    while (!done_seen) begin
      @(posedge clk);
      cyc++;
      #2;
      i_start     = restart && (cyc == 4);
      i_base_addr = (restart && cyc == 4) ? base + 6'd32 : base;
      @(negedge clk);
      if (o_done) begin
        done_seen = 1'b1;
        check_val("o_busy at done", 32'(o_busy), 32'd0);
      end else if (cyc >= 40) begin
        stop_with_error("o_done did not pulse within 40 cycles of start");
      end else begin
        check_val("o_busy", 32'(o_busy), 32'd1);
      end
    end
    check_val("o_done latency", 32'(cyc), 32'd19);
    // a dropped restart leaves the unit idle, no second done
    for (int i = 0; i < 24; i++) begin
      @(negedge clk);
      check_val("o_done after burst", 32'(o_done), 32'd0);
      check_val("o_busy after burst", 32'(o_busy), 32'd0);
    end
  endtask

  // one read per cycle over every bank word
  task automatic read_all();
    int wait_cyc;
    for (int b = 0; b < `ACC_NBANKS; b++) begin
      for (int a = 0; a < `ACC_BANK_DEPTH; a++) begin
        @(posedge clk);
        #2;
        i_rd_en   = 1'b1;
        i_rd_bank = 2'(b);
        i_rd_addr = 4'(a);
        exp_q.push_back('{cyc: cycle_cnt, bank: 2'(b), addr: 4'(a), data: ref_mem[b][a]});
      end
    end
    @(posedge clk);
    #2;
    i_rd_en = 1'b0;
    wait_cyc = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      wait_cyc++;
      if (wait_cyc > 8) begin
        stop_with_error("readback data did not arrive for all requested words");
      end
    end
  endtask

  task automatic run_program(input logic [`ACC_IM_AW-1:0] base, input bit restart);
    load_program(base);
    run_burst(base, restart);
    for (int i = 0; i < `ACC_BURST; i++) begin
      apply_ref(prog[i]);
    end
    read_all();
  endtask

  // compare every readback with the model, latency too
  always @(negedge clk) begin
    if (!rst && o_rd_valid) begin
      if (exp_q.size() == 0) begin
        stop_with_error("o_rd_valid went high with no read pending");
      end else begin
        exp_head = exp_q.pop_front();
        check_val($sformatf("o_rd_data bank %0d word %0d", exp_head.bank, exp_head.addr),
                  32'(o_rd_data), 32'(exp_head.data));
        check_val("o_rd_valid latency", cycle_cnt - exp_head.cyc, 32'd2);
      end
    end
  end

  initial begin
    logic [`ACC_IM_AW-1:0] base;
    int sel;
    void'($urandom(32'hb95c3d59));
    rst         = 1'b1;
    i_im_we     = 1'b0;
    i_im_addr   = '0;
    i_im_wdata  = '0;
    i_start     = 1'b0;
    i_base_addr = '0;
    i_rd_en     = 1'b0;
    i_rd_bank   = '0;
    i_rd_addr   = '0;
    for (int b = 0; b < `ACC_NBANKS; b++) begin
      for (int a = 0; a < `ACC_BANK_DEPTH; a++) begin
        ref_mem[b][a] = '0;
      end
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    // idle after reset, banks cleared
    @(negedge clk);
    check_val("o_busy", 32'(o_busy), 32'd0);
    check_val("o_done", 32'(o_done), 32'd0);
    check_val("o_rd_valid", 32'(o_rd_valid), 32'd0);
    read_all();

    // 16 loads, every bank and word pair distinct
    for (int i = 0; i < `ACC_BURST; i++) begin
      prog[i] = make_instr(OP_LOAD, 16'h1000 + 16'(i) * 16'h0111, 4'(i), 2'(i));
    end
    run_program(6'd0, 1'b0);

    // acc with overflow, load, nop and an unknown code
    for (int i = 0; i < `ACC_BURST; i++) begin
      case (i % 4)
        0: prog[i] = make_instr(OP_ACC, 16'hf00f + 16'(i), 4'(i / 8), 2'd0);
        1: prog[i] = make_instr(OP_LOAD, 16'hfff0 + 16'(i), 4'(i), 2'(i / 4));
        2: prog[i] = make_instr(OP_NOP, 16'hdead, 4'(i), 2'd1);
        default: prog[i] = make_instr(8'h84, 16'hbeef, 4'(i), 2'd2);
      endcase
    end
    run_program(6'd16, 1'b0);

    // wrap from 56, back-to-back acc on one word, restart while busy
    for (int i = 0; i < `ACC_BURST; i++) begin
      if (i == 0) begin
        prog[i] = make_instr(OP_LOAD, 16'hc000, 4'd5, 2'd3);
      end else begin
        prog[i] = make_instr(OP_ACC, 16'h0f0f + 16'(i), 4'd5, 2'd3);
      end
    end
    run_program(6'd56, 1'b1);

    // random programs, sel 7 keeps a random opcode byte
    for (int p = 0; p < 6; p++) begin
      for (int i = 0; i < `ACC_BURST; i++) begin
        sel = int'($urandom_range(7, 0));
        prog[i] = instr_t'({$urandom(), $urandom()});
        if (sel == 0) begin
          prog[i].opcode = OP_NOP;
        end else if (sel <= 3) begin
          prog[i].opcode = OP_LOAD;
        end else if (sel <= 6) begin
          prog[i].opcode = OP_ACC;
        end
      end
      base = 6'($urandom());
      run_program(base, 1'b0);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/accel_pkg.sv
design/instr_mem.sv
design/instr_fetch.sv
design/instr_decode.sv
design/feature_bank.sv
design/bank_readout.sv
design/accel_ctrl_top.sv
verification/accel_checker.sv
verification/accel_tb.sv

//--- Makefile
# Verilator build for the accelerator control testbench

VERILATOR  ?= verilator
TOP        := accel_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator exit status carries pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
